// File: logic/uartPkg.sv
package uartPkg;

  ////////////////////////////////////////
  // Character and queue sizing
  ////////////////////////////////////////

  localparam int DATA_BITS = 8;                  // Bits per character.
  localparam int FIFO_DEPTH = 16;                // Entries per FIFO.

  ////////////////////////////////////////
  // Baud timing
  ////////////////////////////////////////

  localparam int SAMPLE_DIVISOR = 4;             // Clocks per sample tick.
  localparam int SAMPLES_PER_BIT = 16;           // Sample ticks per serial bit.
  localparam int BIT_CYCLES = SAMPLE_DIVISOR * SAMPLES_PER_BIT;

  localparam int DIVIDER_BITS = $clog2(SAMPLE_DIVISOR);
  localparam int TICK_BITS = $clog2(SAMPLES_PER_BIT);
  localparam int BIT_INDEX_BITS = $clog2(DATA_BITS);

  ////////////////////////////////////////
  // Frame FSM states, shared by both directions
  ////////////////////////////////////////

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_START = 2'd1;
  localparam logic [1:0] ST_DATA = 2'd2;
  localparam logic [1:0] ST_STOP = 2'd3;

endpackage

// File: logic/Fifo.sv
`timescale 1ns/100ps

module Fifo
  import uartPkg::*;
#(
  parameter int WIDTH = DATA_BITS,
  parameter int DEPTH = FIFO_DEPTH
) (
  input  logic             CLK,
  input  logic             RESETN,
  input  logic [WIDTH-1:0] DIN,
  output logic [WIDTH-1:0] DOUT,
  input  logic             WE,
  input  logic             RE,
  output logic             NOT_EMPTY,
  output logic             FULL
);

  localparam int ADDR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int SLOTS = 2 ** ADDR_BITS;         // Depth rounded up to a power of two.

  logic [WIDTH-1:0] mem [SLOTS];
  logic [WIDTH-1:0] doutReg;

  logic [ADDR_BITS:0] wrPtr;                     // Extra MSB tells full from empty.
  logic [ADDR_BITS:0] rdPtr;
  logic [ADDR_BITS:0] wrPtrNext;
  logic [ADDR_BITS:0] rdPtrNext;

  logic wrEn;
  logic rdEn;
  logic notEmptyReg;
  logic notEmptyNext;
  logic fullReg;
  logic fullNext;

  ////////////////////////////////////////
  // Pointer arithmetic
  ////////////////////////////////////////

  assign wrEn = WE & ~fullReg;                   // Writes to a full FIFO are dropped.
  assign rdEn = RE & notEmptyReg;                // Reads from an empty FIFO are dropped.

  assign wrPtrNext = wrPtr + {{ADDR_BITS{1'b0}}, wrEn};
  assign rdPtrNext = rdPtr + {{ADDR_BITS{1'b0}}, rdEn};

  assign fullNext = (wrPtrNext[ADDR_BITS] != rdPtrNext[ADDR_BITS]) &&
                    (wrPtrNext[ADDR_BITS-1:0] == rdPtrNext[ADDR_BITS-1:0]);
  assign notEmptyNext = (wrPtrNext != rdPtrNext);

  assign DOUT = doutReg;
  assign NOT_EMPTY = notEmptyReg;
  assign FULL = fullReg;

  ////////////////////////////////////////
  // Storage and read port
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (wrEn) begin
      mem[wrPtr[ADDR_BITS-1:0]] <= DIN;
    end
  end

  // Head entry is prefetched so DOUT always shows the oldest word.
  always_ff @(posedge CLK) begin
    if (wrEn && (wrPtr[ADDR_BITS-1:0] == rdPtrNext[ADDR_BITS-1:0])) begin
      doutReg <= DIN;                            // Bypass into an empty head.
    end else begin
      doutReg <= mem[rdPtrNext[ADDR_BITS-1:0]];
    end
  end

  ////////////////////////////////////////
  // Control state
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      wrPtr <= wrPtrNext;
      rdPtr <= rdPtrNext;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      fullReg <= 1'b0;
      notEmptyReg <= 1'b0;
    end else begin
      fullReg <= fullNext;
      notEmptyReg <= notEmptyNext;
    end
  end

endmodule

// File: logic/baudGenerator.sv
`timescale 1ns/100ps

module baudGenerator
  import uartPkg::*;
(
  input  logic CLK,
  input  logic RESETN,
  output logic sampleTick
);

  logic [DIVIDER_BITS-1:0] divCount;
  logic                    divWrap;

  assign divWrap = (divCount == DIVIDER_BITS'(SAMPLE_DIVISOR - 1));

  // One tick per SAMPLE_DIVISOR clocks, shared by both directions.
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      divCount <= '0;
      sampleTick <= 1'b0;
    end else begin
      sampleTick <= divWrap;
      if (divWrap) begin
        divCount <= '0;
      end else begin
        divCount <= divCount + 1'b1;
      end
    end
  end

endmodule

// File: logic/uartTransmitter.sv
`timescale 1ns/100ps

module uartTransmitter
  import uartPkg::*;
(
  input  logic                 CLK,
  input  logic                 RESETN,
  input  logic                 sampleTick,
  input  logic [DATA_BITS-1:0] txByte,
  input  logic                 txAvailable,
  output logic                 txPop,
  output logic                 TXD
);

  logic [1:0]                state;
  logic [TICK_BITS-1:0]      tickCount;          // Free running, marks bit boundaries.
  logic [BIT_INDEX_BITS-1:0] bitCount;
  logic [DATA_BITS-1:0]      shiftReg;
  logic                      bitEnd;
  logic                      lastBit;
  logic                      shiftBit;

  assign bitEnd = sampleTick && (tickCount == TICK_BITS'(SAMPLES_PER_BIT - 1));
  assign lastBit = (bitCount == BIT_INDEX_BITS'(DATA_BITS - 1));

  // Pop on the edge that starts a new frame.
  assign txPop = bitEnd && txAvailable && ((state == ST_IDLE) || (state == ST_STOP));
  assign shiftBit = bitEnd && ((state == ST_START) || ((state == ST_DATA) && !lastBit));

  always_ff @(posedge CLK) begin
    if (txPop) begin
      shiftReg <= txByte;
    end else if (shiftBit) begin
      shiftReg <= shiftReg >> 1;                 // LSB first.
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      state <= ST_IDLE;
      tickCount <= '0;
      bitCount <= '0;
      TXD <= 1'b1;
    end else begin
      if (sampleTick) begin
        tickCount <= bitEnd ? '0 : tickCount + 1'b1;
      end
      if (bitEnd) begin
        case (state)
          ST_START: begin
            state <= ST_DATA;
            bitCount <= '0;
            TXD <= shiftReg[0];
          end
          ST_DATA: begin
            if (lastBit) begin
              state <= ST_STOP;
              TXD <= 1'b1;                       // Stop bit.
            end else begin
              bitCount <= bitCount + 1'b1;
              TXD <= shiftReg[0];
            end
          end
          default: begin                         // Idle or stop, back to back allowed.
            if (txAvailable) begin
              state <= ST_START;
              TXD <= 1'b0;
            end else begin
              state <= ST_IDLE;
              TXD <= 1'b1;
            end
          end
        endcase
      end
    end
  end

endmodule

// File: logic/uartReceiver.sv
`timescale 1ns/100ps

module uartReceiver
  import uartPkg::*;
(
  input  logic                 CLK,
  input  logic                 RESETN,
  input  logic                 sampleTick,
  input  logic                 RXD,
  input  logic                 rxFifoFull,
  output logic [DATA_BITS-1:0] rxByte,
  output logic                 rxPush,
  output logic                 rxOverrun,
  output logic                 rxFrameError
);

  logic [1:0]                state;
  logic [TICK_BITS-1:0]      tickCount;
  logic [BIT_INDEX_BITS-1:0] bitCount;
  logic [DATA_BITS-1:0]      shiftReg;

  logic rxdMeta;
  logic rxdSync;
  logic rxdLast;
  logic fallingEdge;
  logic halfBit;
  logic fullBit;

  assign fallingEdge = rxdLast && !rxdSync;
  assign halfBit = sampleTick && (tickCount == TICK_BITS'(SAMPLES_PER_BIT / 2 - 1));
  assign fullBit = sampleTick && (tickCount == TICK_BITS'(SAMPLES_PER_BIT - 1));

  assign rxByte = shiftReg;

  ////////////////////////////////////////
  // Data capture
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if ((state == ST_DATA) && fullBit) begin
      shiftReg <= {rxdSync, shiftReg[DATA_BITS-1:1]};  // LSB arrives first.
    end
  end

  ////////////////////////////////////////
  // Frame FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      rxdMeta <= 1'b1;
      rxdSync <= 1'b1;
      rxdLast <= 1'b1;
      state <= ST_IDLE;
      tickCount <= '0;
      bitCount <= '0;
      rxPush <= 1'b0;
      rxOverrun <= 1'b0;
      rxFrameError <= 1'b0;
    end else begin
      rxdMeta <= RXD;                            // Two-stage synchronizer.
      rxdSync <= rxdMeta;
      rxdLast <= rxdSync;
      rxPush <= 1'b0;
      if (sampleTick) begin
        tickCount <= tickCount + 1'b1;
      end
      case (state)
        ST_IDLE: begin
          if (fallingEdge) begin
            state <= ST_START;
            tickCount <= '0;
          end
        end
        ST_START: begin
          if (halfBit) begin
            tickCount <= '0;
            bitCount <= '0;
            state <= rxdSync ? ST_IDLE : ST_DATA;  // High at mid start is a glitch.
          end
        end
        ST_DATA: begin
          if (fullBit) begin
            tickCount <= '0;
            bitCount <= bitCount + 1'b1;
            if (bitCount == BIT_INDEX_BITS'(DATA_BITS - 1)) begin
              state <= ST_STOP;
            end
          end
        end
        default: begin
          if (fullBit) begin                     // Middle of the stop bit.
            tickCount <= '0;
            state <= ST_IDLE;
            if (!rxdSync) begin
              rxFrameError <= 1'b1;
            end else if (rxFifoFull) begin
              rxOverrun <= 1'b1;
            end else begin
              rxPush <= 1'b1;
            end
          end
        end
      endcase
    end
  end

endmodule

// File: logic/uartLink.sv
`timescale 1ns/100ps

module uartLink
  import uartPkg::*;
(
  input  logic                 CLK,
  input  logic                 RESETN,
  input  logic [DATA_BITS-1:0] txData,
  input  logic                 txWrite,
  input  logic                 rxRead,
  output logic                 txFull,
  output logic [DATA_BITS-1:0] rxData,
  output logic                 rxNotEmpty,
  output logic                 rxOverrun,
  output logic                 rxFrameError,
  output logic                 TXD,
  input  logic                 RXD
);

  logic                 sampleTick;
  logic [DATA_BITS-1:0] txHead;                  // Oldest byte waiting to go out.
  logic                 txNotEmpty;
  logic                 txPop;
  logic [DATA_BITS-1:0] rxByte;
  logic                 rxPush;
  logic                 rxFifoFull;

  baudGenerator baudGen (
    .CLK        (CLK),
    .RESETN     (RESETN),
    .sampleTick (sampleTick)
  );

  ////////////////////////////////////////
  // Transmit path
  ////////////////////////////////////////

  Fifo #(.WIDTH(DATA_BITS), .DEPTH(FIFO_DEPTH)) txFifo (
    .CLK       (CLK),
    .RESETN    (RESETN),
    .DIN       (txData),
    .DOUT      (txHead),
    .WE        (txWrite),
    .RE        (txPop),
    .NOT_EMPTY (txNotEmpty),
    .FULL      (txFull)
  );

  uartTransmitter transmitter (
    .CLK         (CLK),
    .RESETN      (RESETN),
    .sampleTick  (sampleTick),
    .txByte      (txHead),
    .txAvailable (txNotEmpty),
    .txPop       (txPop),
    .TXD         (TXD)
  );

  ////////////////////////////////////////
  // Receive path
  ////////////////////////////////////////

  uartReceiver receiver (
    .CLK          (CLK),
    .RESETN       (RESETN),
    .sampleTick   (sampleTick),
    .RXD          (RXD),
    .rxFifoFull   (rxFifoFull),
    .rxByte       (rxByte),
    .rxPush       (rxPush),
    .rxOverrun    (rxOverrun),
    .rxFrameError (rxFrameError)
  );

  Fifo #(.WIDTH(DATA_BITS), .DEPTH(FIFO_DEPTH)) rxFifo (
    .CLK       (CLK),
    .RESETN    (RESETN),
    .DIN       (rxByte),
    .DOUT      (rxData),
    .WE        (rxPush),
    .RE        (rxRead),                         // Host pops directly.
    .NOT_EMPTY (rxNotEmpty),
    .FULL      (rxFifoFull)
  );

endmodule

// File: dv/uartLinkChecker.sv
`timescale 1ns/100ps

module uartLinkChecker
  import uartPkg::*;
(
  input logic                        CLK,
  input logic                        RESETN,
  input logic                        TXD,
  input logic                        txFull,
  input logic                        rxNotEmpty,
  input logic                        rxOverrun,
  input logic                        rxFrameError,
  input logic [$clog2(FIFO_DEPTH):0] txWrPtr,
  input logic                        rxPush,
  input logic                        rxRead
);

  int assertFailures = 0;
  int rxLevel;                                   // Bytes held in the receive FIFO.

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      rxLevel <= 0;
    end else begin
      rxLevel <= rxLevel + int'(rxPush) - int'(rxRead && rxNotEmpty);
    end
  end

  txdIdleInReset: assert property (@(posedge CLK) !RESETN |=> TXD)
    else begin
      assertFailures++;
      $error("TXD left idle while reset was active");
    end

  // Level counted from pushes and accepted host reads.
  rxEmptyConsistent: assert property (@(posedge CLK) disable iff (!RESETN)
      (rxLevel == 0) |-> !(txFull && rxNotEmpty))
    else begin
      assertFailures++;
      $error("rxNotEmpty and txFull both high with an empty receive FIFO");
    end

  noPushWhenFull: assert property (@(posedge CLK) disable iff (!RESETN)
      txFull |=> $stable(txWrPtr))
    else begin
      assertFailures++;
      $error("Transmit FIFO accepted a write while full");
    end

  stickyFlags: assert property (@(posedge CLK)
      (RESETN && $past(RESETN)) |-> (!$fell(rxOverrun) && !$fell(rxFrameError)))
    else begin
      assertFailures++;
      $error("Receive error flag cleared without reset");
    end

endmodule

bind uartLink uartLinkChecker linkChecker (
  .CLK          (CLK),
  .RESETN       (RESETN),
  .TXD          (TXD),
  .txFull       (txFull),
  .rxNotEmpty   (rxNotEmpty),
  .rxOverrun    (rxOverrun),
  .rxFrameError (rxFrameError),
  .txWrPtr      (txFifo.wrPtr),
  .rxPush       (rxPush),
  .rxRead       (rxRead)
);

// File: dv/uartLinkTb.sv
`timescale 1ns/100ps

module uartLinkTb
  import uartPkg::*;
();

  logic                 CLK;
  logic                 RESETN;
  logic [DATA_BITS-1:0] txData;
  logic                 txWrite;
  logic                 rxRead;
  logic                 txFull;
  logic [DATA_BITS-1:0] rxData;
  logic                 rxNotEmpty;
  logic                 rxOverrun;
  logic                 rxFrameError;
  logic                 TXD;
  logic                 RXD;

  logic                 loopback;                // Routes TXD back into RXD.
  logic                 lineDrive;
  logic [DATA_BITS-1:0] expected[$];             // Bytes due on rxData, oldest first.
  int                   txLevel;
  int                   checkCount;
  int                   errorCount;
  int                   timeoutCount;

  assign RXD = loopback ? TXD : lineDrive;

  uartLink uut (
    .CLK          (CLK),
    .RESETN       (RESETN),
    .txData       (txData),
    .txWrite      (txWrite),
    .rxRead       (rxRead),
    .txFull       (txFull),
    .rxData       (rxData),
    .rxNotEmpty   (rxNotEmpty),
    .rxOverrun    (rxOverrun),
    .rxFrameError (rxFrameError),
    .TXD          (TXD),
    .RXD          (RXD)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic checkByte(input string name, input logic [DATA_BITS-1:0] expectedValue,
                           input logic [DATA_BITS-1:0] actualValue);
    checkCount++;
    if (actualValue !== expectedValue) begin
      errorCount++;
      $display("Error %s: expected %h, actual %h", name, expectedValue, actualValue);
    end
  endtask

  task automatic checkFlag(input string name, input logic expectedValue,
                           input logic actualValue);
    checkCount++;
    if (actualValue !== expectedValue) begin
      errorCount++;
      $display("Error %s: expected %b, actual %b", name, expectedValue, actualValue);
    end
  endtask

  ////////////////////////////////////////
  // Drivers and waits
  ////////////////////////////////////////

  task automatic applyReset();
    @(negedge CLK);
    RESETN = 1'b0;
    txWrite = 1'b0;
    rxRead = 1'b0;
    repeat (16) @(negedge CLK);
    RESETN = 1'b1;
    txLevel = 0;
  endtask

  task automatic hostWrite(input logic [DATA_BITS-1:0] data, input bit accepted);
    txData = data;
    txWrite = 1'b1;
    if (accepted) begin
      expected.push_back(data);
    end
    @(negedge CLK);
    txWrite = 1'b0;
  endtask

  task automatic waitTxRoom(input string name);
    int waited;
    waited = 0;
    while (txFull && waited < 2 * 10 * BIT_CYCLES) begin
      @(negedge CLK);
      waited++;
    end
    if (txFull) begin
      timeoutCount++;
      $display("%s: transmit FIFO stayed full too long", name);
    end
  endtask

  task automatic waitOverrun(input string name);
    int waited;
    waited = 0;
    while (!rxOverrun && waited < 40 * 10 * BIT_CYCLES) begin
      @(negedge CLK);
      waited++;
    end
    if (!rxOverrun) begin
      timeoutCount++;
      $display("%s: receive overrun never occurred", name);
    end
  endtask

  task automatic readBytes(input string name, input int count);
    int waited;
    for (int i = 0; i < count; i++) begin
      waited = 0;
      while (!rxNotEmpty && waited < 20 * 10 * BIT_CYCLES) begin
        @(negedge CLK);
        waited++;
      end
      if (!rxNotEmpty) begin
        timeoutCount++;
        $display("%s: byte %0d never arrived", name, i);
        return;
      end
      if (expected.size() == 0) begin
        errorCount++;
        $display("%s: a byte arrived that was never sent", name);
        return;
      end
      checkByte(name, expected.pop_front(), rxData);
      rxRead = 1'b1;
      @(negedge CLK);
      rxRead = 1'b0;
    end
  endtask

  // Hand-built 8N1 frame on the direct line.
  task automatic sendFrame(input logic [DATA_BITS-1:0] data, input logic stopBit);
    lineDrive = 1'b0;
    repeat (BIT_CYCLES) @(negedge CLK);
    for (int i = 0; i < DATA_BITS; i++) begin
      lineDrive = data[i];
      repeat (BIT_CYCLES) @(negedge CLK);
    end
    lineDrive = stopBit;
    repeat (BIT_CYCLES) @(negedge CLK);
    lineDrive = 1'b1;                            // One idle bit.
    repeat (BIT_CYCLES) @(negedge CLK);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    logic [DATA_BITS-1:0] value;
    void'($urandom(54));
    RESETN = 1'b0;
    txData = '0;
    txWrite = 1'b0;
    rxRead = 1'b0;
    loopback = 1'b1;
    lineDrive = 1'b1;
    txLevel = 0;
    checkCount = 0;
    errorCount = 0;
    timeoutCount = 0;
    applyReset();

    checkFlag("resetTxd", 1'b1, TXD);
    checkFlag("resetTxFull", 1'b0, txFull);
    checkFlag("resetRxNotEmpty", 1'b0, rxNotEmpty);
    checkFlag("resetRxOverrun", 1'b0, rxOverrun);
    checkFlag("resetRxFrameError", 1'b0, rxFrameError);

    fork
      begin
        for (int i = 0; i < 40; i++) begin
          repeat ($urandom_range(0, 2 * BIT_CYCLES)) @(negedge CLK);
          waitTxRoom("randomLoopback");
          hostWrite(DATA_BITS'($urandom), 1'b1);
        end
      end
      readBytes("randomLoopback", 40);
    join

    fork
      begin
        hostWrite(DATA_BITS'($urandom), 1'b1);
        repeat (2 * BIT_CYCLES) @(negedge CLK);  // First byte now in flight.
        for (int i = 0; i < 20; i++) begin
          hostWrite(DATA_BITS'($urandom), txLevel < FIFO_DEPTH);
          if (txLevel < FIFO_DEPTH) begin
            txLevel++;
          end
        end
        checkFlag("burstTxFull", 1'b1, txFull);
      end
      readBytes("burstLoopback", 1 + FIFO_DEPTH);
    join
    repeat (2 * 10 * BIT_CYCLES) @(negedge CLK);
    checkFlag("burstNoExtra", 1'b0, rxNotEmpty);

    fork
      begin
        for (int i = 0; i < FIFO_DEPTH + 4; i++) begin
          waitTxRoom("overrunLoopback");
          hostWrite(DATA_BITS'($urandom), 1'b1);
        end
      end
      waitOverrun("overrunLoopback");
    join
    repeat (4 * 10 * BIT_CYCLES) @(negedge CLK); // Last frames hit a full FIFO.
    checkFlag("overrunFlag", 1'b1, rxOverrun);
    readBytes("overrunLoopback", FIFO_DEPTH);
    checkFlag("overrunDropped", 1'b0, rxNotEmpty);
    expected.delete();

    applyReset();
    loopback = 1'b0;
    sendFrame(DATA_BITS'($urandom), 1'b0);
    checkFlag("badStopFrameError", 1'b1, rxFrameError);
    checkFlag("badStopNoData", 1'b0, rxNotEmpty);
    value = DATA_BITS'($urandom);
    expected.push_back(value);
    sendFrame(value, 1'b1);
    readBytes("goodFrame", 1);
    checkFlag("frameErrorHeld", 1'b1, rxFrameError);

    errorCount += uut.linkChecker.assertFailures;
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checkCount, errorCount, timeoutCount);
    if ((errorCount == 0) && (timeoutCount == 0)) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: uartLink.f
logic/uartPkg.sv
logic/Fifo.sv
logic/baudGenerator.sv
logic/uartTransmitter.sv
logic/uartReceiver.sv
logic/uartLink.sv
dv/uartLinkChecker.sv
dv/uartLinkTb.sv

// File: Bender.yml
package:
  name: uartLink

sources:
  - logic/uartPkg.sv
  - logic/Fifo.sv
  - logic/baudGenerator.sv
  - logic/uartTransmitter.sv
  - logic/uartReceiver.sv
  - logic/uartLink.sv
  - target: test
    files:
      - dv/uartLinkChecker.sv
      - dv/uartLinkTb.sv
